//--- src.f
+incdir+verilog
verilog/gat_data_pkg.sv
verilog/gat_addr_pkg.sv
verilog/gat_bram.sv
verilog/gat_load_ctrl.sv
verilog/gat_spmm.sv
verilog/gat_wh_buffer.sv
verilog/gat_top.sv
tb/gat_top_tb.sv

//--- tb/gat_top_tb.sv
`timescale 1ns/1ns
`include "gat_defs.svh"

module gat_top_tb
  import gat_data_pkg::*, gat_addr_pkg::*;
();

  localparam int n_nodes = `GAT_TOTAL_NODES;
  localparam int n_in    = `GAT_NUM_FEATURE_IN;
  localparam int n_out   = `GAT_NUM_FEATURE_OUT;

  logic       clk;
  logic       rst;
  h_entry_t   h_data_bram_din;
  logic       h_data_bram_ena;
  h_addr_t    h_data_bram_addra;
  node_info_t h_node_info_bram_din;
  logic       h_node_info_bram_ena;
  node_idx_t  h_node_info_bram_addra;
  weight_t    wgt_bram_din;
  logic       wgt_bram_ena;
  wgt_addr_t  wgt_bram_addra;
  logic       h_data_bram_load_done;
  logic       h_node_info_bram_load_done;
  logic       wgt_bram_load_done;
  wh_addr_t   wh_out_addr;
  wh_t        wh_out_dout;
  logic       gat_ready;

  integer     seed;
  int         n_entries;
  node_info_t info [n_nodes];
  h_entry_t   ent [`GAT_H_DATA_DEPTH];
  weight_t    wgt [n_in][n_out];
  int         exp_wh [n_nodes][n_out];

  gat_top gat_top_i (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ============================================================
  // Checks
  // ============================================================
  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_wh(input string name, input wh_t expected, input wh_t actual);
    if (actual !== expected) begin
      abort_run($sformatf("[FAIL] %s expected %0d actual %0d", name, expected, actual));
    end
  endtask

  task automatic check_ready(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      abort_run($sformatf("[FAIL] %s gat_ready expected %b actual %b", name, expected, actual));
    end
  endtask

  // ============================================================
  // Stimulus and model
  // ============================================================
  task automatic reset_dut();
    @(posedge clk);
    rst                        <= 1'b1;
    h_data_bram_load_done      <= 1'b0;
    h_node_info_bram_load_done <= 1'b0;
    wgt_bram_load_done         <= 1'b0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
  endtask

  // Mode 0 random, mode 1 with empty rows, mode 2 all at -128
  task automatic gen_case(input int mode);
    int len;
    int rnd;
    int p;
    p = 0;
    for (int r = 0; r < n_in; r++) begin
      for (int c = 0; c < n_out; c++) begin
        rnd = $random(seed);
        wgt[r][c] = (mode == 2) ? 8'sh80 : rnd[`GAT_DATA_WIDTH-1:0];
      end
    end
    for (int n = 0; n < n_nodes; n++) begin
      case (mode)
        0:       len = {$random(seed)} % 9;
        1:       len = (n % 3 == 1) ? 0 : {$random(seed)} % 8 + 1;
        // Only 64 entries fit, so five rows are fully dense
        default: len = (n < 5) ? n_in : 3;
      endcase
      info[n].row_len = len[row_len_w-1:0];
      for (int k = 0; k < len; k++) begin
        rnd = $random(seed);
        if (mode == 2) begin
          ent[p].val = 8'sh80;
          ent[p].col = feat_in_idx_t'(k);
        end else begin
          ent[p].val = rnd[`GAT_DATA_WIDTH-1:0];
          ent[p].col = feat_in_idx_t'({$random(seed)} % n_in);
        end
        p++;
      end
    end
    n_entries = p;
  endtask

  task automatic compute_expected();
    int p;
    p = 0;
    for (int n = 0; n < n_nodes; n++) begin
      for (int f = 0; f < n_out; f++) begin
        exp_wh[n][f] = 0;
      end
      for (int k = 0; k < int'(info[n].row_len); k++) begin
        for (int f = 0; f < n_out; f++) begin
          exp_wh[n][f] += int'(ent[p].val) * int'(wgt[ent[p].col][f]);
        end
        p++;
      end
    end
  endtask

  task automatic write_features();
    for (int n = 0; n < n_nodes; n++) begin
      @(posedge clk);
      h_node_info_bram_ena   <= 1'b1;
      h_node_info_bram_addra <= node_idx_t'(n);
      h_node_info_bram_din   <= info[n];
    end
    for (int e = 0; e < n_entries; e++) begin
      @(posedge clk);
      h_node_info_bram_ena <= 1'b0;
      h_data_bram_ena      <= 1'b1;
      h_data_bram_addra    <= h_addr_t'(e);
      h_data_bram_din      <= ent[e];
    end
    @(posedge clk);
    h_node_info_bram_ena <= 1'b0;
    h_data_bram_ena      <= 1'b0;
  endtask

  task automatic write_weights();
    for (int a = 0; a < n_in * n_out; a++) begin
      @(posedge clk);
      wgt_bram_ena   <= 1'b1;
      wgt_bram_addra <= wgt_addr_t'(a);
      wgt_bram_din   <= wgt[a / n_out][a % n_out];
    end
    @(posedge clk);
    wgt_bram_ena <= 1'b0;
  endtask

  task automatic load_all();
    write_features();
    write_weights();
    @(posedge clk);
    h_data_bram_load_done      <= 1'b1;
    h_node_info_bram_load_done <= 1'b1;
    wgt_bram_load_done         <= 1'b1;
  endtask

  task automatic wait_ready(input string test);
    int cycles;
    cycles = 0;
    while (gat_ready !== 1'b1) begin
      @(negedge clk);
      cycles++;
      if (cycles > 4000) begin
        abort_run($sformatf("%s: gat_ready did not rise within 4000 cycles", test));
      end
    end
  endtask

  task automatic read_wh(input wh_addr_t addr, output wh_t data);
    @(posedge clk);
    wh_out_addr <= addr;
    @(posedge clk);
    @(negedge clk);
    data = wh_out_dout;
  endtask

  task automatic check_results(input string test);
    wh_t got;
    compute_expected();
    wait_ready(test);
    for (int a = 0; a < n_nodes * n_out; a++) begin
      read_wh(wh_addr_t'(a), got);
      check_ready(test, 1'b1, gat_ready);
      check_wh($sformatf("%s node %0d feature %0d", test, a / n_out, a % n_out),
               wh_t'(exp_wh[a / n_out][a % n_out]), got);
    end
  endtask

  task automatic run_and_check(input string test);
    load_all();
    check_results(test);
  endtask

  // ============================================================
  // Tests
  // ============================================================
  task automatic test_ready_gating();
    reset_dut();
    @(negedge clk);
    check_ready("ready_gating after reset", 1'b0, gat_ready);
    gen_case(0);
    write_features();
    @(posedge clk);
    h_data_bram_load_done      <= 1'b1;
    h_node_info_bram_load_done <= 1'b1;
    repeat (50) begin
      @(negedge clk);
      check_ready("ready_gating two of three", 1'b0, gat_ready);
    end
    // An early start would run on an unwritten W
    write_weights();
    @(posedge clk);
    wgt_bram_load_done <= 1'b1;
    check_results("ready_gating");
  endtask

  task automatic test_stable_readback();
    wh_t got;
    reset_dut();
    gen_case(0);
    run_and_check("stable_readback");
    for (int a = 0; a < n_nodes * n_out; a++) begin
      read_wh(wh_addr_t'(a), got);
      check_ready("stable_readback second pass", 1'b1, gat_ready);
      check_wh($sformatf("stable_readback repeat addr %0d", a),
               wh_t'(exp_wh[a / n_out][a % n_out]), got);
    end
  endtask

  initial begin
    seed = 98924;
    rst                        <= 1'b1;
    h_data_bram_din            <= '0;
    h_data_bram_ena            <= 1'b0;
    h_data_bram_addra          <= '0;
    h_node_info_bram_din       <= '0;
    h_node_info_bram_ena       <= 1'b0;
    h_node_info_bram_addra     <= '0;
    wgt_bram_din               <= '0;
    wgt_bram_ena               <= 1'b0;
    wgt_bram_addra             <= '0;
    h_data_bram_load_done      <= 1'b0;
    h_node_info_bram_load_done <= 1'b0;
    wgt_bram_load_done         <= 1'b0;
    wh_out_addr                <= '0;

    test_ready_gating();
    reset_dut();
    gen_case(0);
    run_and_check("random_sparse");
    reset_dut();
    gen_case(1);
    run_and_check("zero_rows");
    reset_dut();
    gen_case(2);
    run_and_check("extreme_values");
    test_stable_readback();

    $display("Simulation PASSED");
    $finish;
  end

endmodule

//--- verilog/gat_addr_pkg.sv
`include "gat_defs.svh"

package gat_addr_pkg;

  // ============================================================
  // Indices
  // ============================================================
  typedef logic [$clog2(`GAT_H_DATA_DEPTH)-1:0]    h_addr_t;
  typedef logic [$clog2(`GAT_TOTAL_NODES)-1:0]     node_idx_t;
  typedef logic [$clog2(`GAT_NUM_FEATURE_IN)-1:0]  feat_in_idx_t;
  typedef logic [$clog2(`GAT_NUM_FEATURE_OUT)-1:0] feat_out_idx_t;

  // ============================================================
  // Composite addresses
  // ============================================================

  // Weight address is {input row, output column}
  typedef logic [$bits(feat_in_idx_t)+$bits(feat_out_idx_t)-1:0] wgt_addr_t;

  // WH address is {node, output feature}
  typedef logic [$bits(node_idx_t)+$bits(feat_out_idx_t)-1:0] wh_addr_t;

endpackage

//--- verilog/gat_bram.sv
`timescale 1ns/1ns

module gat_bram #(
  parameter type payload_t = logic [7:0],
  parameter int  depth     = 16,
  localparam int addr_w    = $clog2(depth)
)(
  input  logic              clk,

  // Write port
  input  logic              ena,
  input  logic [addr_w-1:0] addra,
  input  payload_t          din,

  // Read port, one cycle latency
  input  logic [addr_w-1:0] addrb,
  output payload_t          doutb
);

  payload_t mem [depth];

  always_ff @(posedge clk) begin
    if (ena) begin
      mem[addra] <= din;
    end
  end

  always_ff @(posedge clk) begin
    doutb <= mem[addrb];
  end

  // Depth need not be a power of two
  a_wr_in_range: assert property (
    @(posedge clk) ena |-> (addra < depth)
  ) else $error("gat_bram write address %0d beyond depth %0d", addra, depth);

endmodule

//--- verilog/gat_data_pkg.sv
`include "gat_defs.svh"

package gat_data_pkg;

  // Column index into one row of H
  localparam int col_idx_w = $clog2(`GAT_NUM_FEATURE_IN);

  // Row length counts 0 up to the full input width
  localparam int row_len_w = $clog2(`GAT_NUM_FEATURE_IN + 1);

  // ============================================================
  // Stored formats
  // ============================================================

  // One nonzero of sparse H
  typedef struct packed {
    logic signed [`GAT_DATA_WIDTH-1:0] val;
    logic [col_idx_w-1:0]              col;
  } h_entry_t;

  // Per-node entry, nonzero count only
  typedef struct packed {
    logic [row_len_w-1:0] row_len;
  } node_info_t;

  typedef logic signed [`GAT_DATA_WIDTH-1:0] weight_t;

  // Accumulated product row element
  typedef logic signed [`GAT_WH_DATA_WIDTH-1:0] wh_t;

endpackage

//--- verilog/gat_defs.svh
`ifndef GAT_DEFS_SVH
`define GAT_DEFS_SVH

// ============================================================
// Layer sizes
// ============================================================
`define GAT_TOTAL_NODES       8
`define GAT_NUM_FEATURE_IN    11
`define GAT_NUM_FEATURE_OUT   16

// ============================================================
// Memory capacity and data widths
// ============================================================
`define GAT_H_DATA_DEPTH      64
`define GAT_DATA_WIDTH        8

// Wide enough for 11 products of two signed 8-bit values
`define GAT_WH_DATA_WIDTH     20

`endif

//--- verilog/gat_load_ctrl.sv
`timescale 1ns/1ns
`include "gat_defs.svh"

module gat_load_ctrl
  import gat_data_pkg::*, gat_addr_pkg::*;
(
  input  logic       clk,
  input  logic       rst,

  // Host write side
  input  h_entry_t   h_data_bram_din,
  input  logic       h_data_bram_ena,
  input  h_addr_t    h_data_bram_addra,
  input  node_info_t h_node_info_bram_din,
  input  logic       h_node_info_bram_ena,
  input  node_idx_t  h_node_info_bram_addra,
  input  weight_t    wgt_bram_din,
  input  logic       wgt_bram_ena,
  input  wgt_addr_t  wgt_bram_addra,

  input  logic       h_data_bram_load_done,
  input  logic       h_node_info_bram_load_done,
  input  logic       wgt_bram_load_done,

  // Core read side
  input  h_addr_t    h_rd_addr,
  output h_entry_t   h_rd_data,
  input  node_idx_t  info_rd_addr,
  output node_info_t info_rd_data,
  input  wgt_addr_t  wgt_rd_addr,
  output weight_t    wgt_rd_data,

  output logic       start
);

  logic all_done;
  logic fired;

  // ============================================================
  // Memories
  // ============================================================
  gat_bram #(.payload_t(h_entry_t), .depth(`GAT_H_DATA_DEPTH)) h_data_bram_i (
    .clk   (clk),
    .ena   (h_data_bram_ena),
    .addra (h_data_bram_addra),
    .din   (h_data_bram_din),
    .addrb (h_rd_addr),
    .doutb (h_rd_data)
  );

  gat_bram #(.payload_t(node_info_t), .depth(`GAT_TOTAL_NODES)) h_node_info_bram_i (
    .clk   (clk),
    .ena   (h_node_info_bram_ena),
    .addra (h_node_info_bram_addra),
    .din   (h_node_info_bram_din),
    .addrb (info_rd_addr),
    .doutb (info_rd_data)
  );

  gat_bram #(
    .payload_t (weight_t),
    .depth     (`GAT_NUM_FEATURE_IN * `GAT_NUM_FEATURE_OUT)
  ) wgt_bram_i (
    .clk   (clk),
    .ena   (wgt_bram_ena),
    .addra (wgt_bram_addra),
    .din   (wgt_bram_din),
    .addrb (wgt_rd_addr),
    .doutb (wgt_rd_data)
  );

  // ============================================================
  // Start, once per reset
  // ============================================================
  assign all_done = h_data_bram_load_done & h_node_info_bram_load_done & wgt_bram_load_done;
  assign start    = all_done & ~fired;

  always_ff @(posedge clk) begin
    if (rst) begin
      fired <= 1'b0;
    end else if (all_done) begin
      fired <= 1'b1;
    end
  end

  // Memories are read by the core from here on
  a_no_late_write: assert property (
    @(posedge clk) disable iff (rst)
    fired |-> !(h_data_bram_ena || h_node_info_bram_ena || wgt_bram_ena)
  ) else $error("host write after start");

endmodule

//--- verilog/gat_spmm.sv
`timescale 1ns/1ns
`include "gat_defs.svh"

module gat_spmm
  import gat_data_pkg::*, gat_addr_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       start,

  output h_addr_t    h_rd_addr,
  input  h_entry_t   h_rd_data,
  output node_idx_t  info_rd_addr,
  input  node_info_t info_rd_data,
  output wgt_addr_t  wgt_rd_addr,
  input  weight_t    wgt_rd_data,

  output logic       wh_we,
  output wh_addr_t   wh_waddr,
  output wh_t        wh_wdata,
  output logic       done
);

  typedef enum logic [2:0] {
    st_idle,
    st_info,
    st_info_data,
    st_entry,
    st_entry_data,
    st_sweep,
    st_write,
    st_done
  } state_t;

  localparam feat_out_idx_t last_feat = feat_out_idx_t'(`GAT_NUM_FEATURE_OUT - 1);
  localparam node_idx_t     last_node = node_idx_t'(`GAT_TOTAL_NODES - 1);

  state_t                            state;
  node_idx_t                         node;
  h_addr_t                           h_ptr;
  feat_in_idx_t                      col;
  feat_out_idx_t                     feat;
  feat_out_idx_t                     mac_feat;
  logic                              mac_valid;
  logic signed [`GAT_DATA_WIDTH-1:0] cur_val;
  logic [$bits(node_info_t)-1:0]     row_left;
  logic signed [2*`GAT_DATA_WIDTH-1:0] product;
  wh_t                               acc [`GAT_NUM_FEATURE_OUT];

  assign h_rd_addr    = h_ptr;
  assign info_rd_addr = node;
  assign wgt_rd_addr  = {col, feat};

  assign wh_we    = (state == st_write);
  assign wh_waddr = {node, feat};
  assign wh_wdata = acc[feat];
  assign done     = (state == st_done);

  assign product = cur_val * wgt_rd_data;

  // ============================================================
  // Node and entry walk
  // ============================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= st_idle;
      node     <= '0;
      h_ptr    <= '0;
      col      <= '0;
      feat     <= '0;
      row_left <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (start) begin
            node  <= '0;
            h_ptr <= '0;
            state <= st_info;
          end
        end
        st_info: state <= st_info_data;
        st_info_data: begin
          row_left <= info_rd_data.row_len;
          feat     <= '0;
          state    <= (info_rd_data.row_len == '0) ? st_write : st_entry;
        end
        st_entry: state <= st_entry_data;
        st_entry_data: begin
          col      <= h_rd_data.col;
          feat     <= '0;
          h_ptr    <= h_ptr + 1'b1;
          row_left <= row_left - 1'b1;
          state    <= st_sweep;
        end
        st_sweep: begin
          // Last MAC of this row lands in the next state
          feat <= feat + 1'b1;
          if (feat == last_feat) begin
            state <= (row_left == '0) ? st_write : st_entry;
          end
        end
        st_write: begin
          feat <= feat + 1'b1;
          if (feat == last_feat) begin
            if (node == last_node) begin
              state <= st_done;
            end else begin
              node  <= node + 1'b1;
              state <= st_info;
            end
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // ============================================================
  // Accumulator, one feature behind the weight read
  // ============================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      mac_valid <= 1'b0;
      for (int i = 0; i < `GAT_NUM_FEATURE_OUT; i++) begin
        acc[i] <= '0;
      end
    end else begin
      mac_valid <= (state == st_sweep);
      if (mac_valid) begin
        acc[mac_feat] <= acc[mac_feat] + product;
      end
      if (state == st_write) begin
        acc[feat] <= '0;
      end
    end
  end

  always_ff @(posedge clk) begin
    mac_feat <= feat;
    if (state == st_entry_data) begin
      cur_val <= h_rd_data.val;
    end
  end

  a_col_in_range: assert property (
    @(posedge clk) disable iff (rst)
    (state == st_entry_data) |-> (h_rd_data.col < `GAT_NUM_FEATURE_IN)
  ) else $error("H column index %0d out of range", h_rd_data.col);

endmodule

//--- verilog/gat_top.sv
`timescale 1ns/1ns

module gat_top
  import gat_data_pkg::*, gat_addr_pkg::*;
(
  input  logic       clk,
  input  logic       rst,

  input  h_entry_t   h_data_bram_din,
  input  logic       h_data_bram_ena,
  input  h_addr_t    h_data_bram_addra,
  input  node_info_t h_node_info_bram_din,
  input  logic       h_node_info_bram_ena,
  input  node_idx_t  h_node_info_bram_addra,
  input  weight_t    wgt_bram_din,
  input  logic       wgt_bram_ena,
  input  wgt_addr_t  wgt_bram_addra,

  input  logic       h_data_bram_load_done,
  input  logic       h_node_info_bram_load_done,
  input  logic       wgt_bram_load_done,

  input  wh_addr_t   wh_out_addr,
  output wh_t        wh_out_dout,
  output logic       gat_ready
);

  logic       start;
  h_addr_t    h_rd_addr;
  h_entry_t   h_rd_data;
  node_idx_t  info_rd_addr;
  node_info_t info_rd_data;
  wgt_addr_t  wgt_rd_addr;
  weight_t    wgt_rd_data;
  logic       wh_we;
  wh_addr_t   wh_waddr;
  wh_t        wh_wdata;
  logic       done;

  // ============================================================
  // Input side, core, output side
  // ============================================================
  gat_load_ctrl gat_load_ctrl_i (.*);

  gat_spmm gat_spmm_i (.*);

  gat_wh_buffer gat_wh_buffer_i (.*);

endmodule

//--- verilog/gat_wh_buffer.sv
`timescale 1ns/1ns
`include "gat_defs.svh"

module gat_wh_buffer
  import gat_data_pkg::*, gat_addr_pkg::*;
(
  input  logic     clk,
  input  logic     rst,

  // From the core
  input  logic     wh_we,
  input  wh_addr_t wh_waddr,
  input  wh_t      wh_wdata,
  input  logic     done,

  // Host readback
  input  wh_addr_t wh_out_addr,
  output wh_t      wh_out_dout,
  output logic     gat_ready
);

  // ============================================================
  // Result memory
  // ============================================================
  gat_bram #(
    .payload_t (wh_t),
    .depth     (`GAT_TOTAL_NODES * `GAT_NUM_FEATURE_OUT)
  ) wh_bram_i (
    .clk   (clk),
    .ena   (wh_we),
    .addra (wh_waddr),
    .din   (wh_wdata),
    .addrb (wh_out_addr),
    .doutb (wh_out_dout)
  );

  // Held until the next reset
  always_ff @(posedge clk) begin
    if (rst) begin
      gat_ready <= 1'b0;
    end else if (done) begin
      gat_ready <= 1'b1;
    end
  end

  // Results stay stable while the host reads
  a_no_write_after_done: assert property (
    @(posedge clk) disable iff (rst)
    gat_ready |-> !wh_we
  ) else $error("WH write after done");

endmodule
